// File: hdl/dual_issue_macros.svh
//////////////////////////////
// Widths, MIPS opcode and function codes for the dual-issue core.
// Include in every RTL file before the package import.
//////////////////////////////
`ifndef DUAL_ISSUE_MACROS_SVH
`define DUAL_ISSUE_MACROS_SVH

`define DI_DATA_W     32
`define DI_REG_AW     5
`define DI_REG_NUM    32
`define DI_PC_STEP    32'd4

// Major opcodes
`define DI_OP_SPECIAL 6'b000000
`define DI_OP_ADDIU   6'b001001
`define DI_OP_ANDI    6'b001100
`define DI_OP_ORI     6'b001101
`define DI_OP_LUI     6'b001111

// SPECIAL function field
`define DI_FN_ADDU    6'b100001
`define DI_FN_SUBU    6'b100011
`define DI_FN_AND     6'b100100
`define DI_FN_OR      6'b100101
`define DI_FN_XOR     6'b100110
`define DI_FN_SLT     6'b101010

`endif

// File: hdl/dual_issue_pkg.sv
//////////////////////////////
// Shared types of the dual-issue core.
// Decoded slots flow decode to execute, result slots execute to commit.
//////////////////////////////
`include "dual_issue_macros.svh"

package dual_issue_pkg;

    typedef enum logic [2:0] {
        ALU_NOP = 3'd0,
        ALU_ADD = 3'd1,
        ALU_SUB = 3'd2,
        ALU_AND = 3'd3,
        ALU_OR  = 3'd4,
        ALU_XOR = 3'd5,
        ALU_SLT = 3'd6,
        ALU_LUI = 3'd7
    } alu_op_e;

    // One decoded instruction, operands already resolved
    typedef struct packed {
        logic                  valid;
        logic [`DI_DATA_W-1:0] pc;
        alu_op_e               alu_op;
        logic [`DI_REG_AW-1:0] rs;
        logic [`DI_REG_AW-1:0] rt;
        logic                  use_imm;
        logic [`DI_DATA_W-1:0] op_a;
        logic [`DI_DATA_W-1:0] op_b;
        logic                  we;
        logic [`DI_REG_AW-1:0] waddr;
    } issue_slot_t;

    // One executed instruction
    typedef struct packed {
        logic [`DI_DATA_W-1:0] pc;
        logic                  we;
        logic [`DI_REG_AW-1:0] waddr;
        logic [`DI_DATA_W-1:0] wdata;
    } result_slot_t;

endpackage

// File: hdl/reg_file.sv
//////////////////////////////
// 32-entry register file, four async reads and two writes.
// Register zero always reads as zero.
//////////////////////////////
`include "dual_issue_macros.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  we1_i,
    input  logic [`DI_REG_AW-1:0] waddr1_i,
    input  logic [`DI_DATA_W-1:0] wdata1_i,
    input  logic                  we2_i,
    input  logic [`DI_REG_AW-1:0] waddr2_i,
    input  logic [`DI_DATA_W-1:0] wdata2_i,
    input  logic [`DI_REG_AW-1:0] raddr1_i,
    input  logic [`DI_REG_AW-1:0] raddr2_i,
    input  logic [`DI_REG_AW-1:0] raddr3_i,
    input  logic [`DI_REG_AW-1:0] raddr4_i,
    output logic [`DI_DATA_W-1:0] rdata1_o,
    output logic [`DI_DATA_W-1:0] rdata2_o,
    output logic [`DI_DATA_W-1:0] rdata3_o,
    output logic [`DI_DATA_W-1:0] rdata4_o
);
    logic [`DI_DATA_W-1:0] regs [`DI_REG_NUM];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `DI_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we1_i) begin
                regs[waddr1_i] <= wdata1_i;
            end
            // Second write lands last, so slot 2 wins a clash
            if (we2_i) begin
                regs[waddr2_i] <= wdata2_i;
            end
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];
    assign rdata3_o = (raddr3_i == '0) ? '0 : regs[raddr3_i];
    assign rdata4_o = (raddr4_i == '0) ? '0 : regs[raddr4_i];

endmodule

// File: hdl/inst_decode.sv
//////////////////////////////
// Decodes one MIPS instruction into an issue slot.
// Operands come from forwarded results or the register file.
//////////////////////////////
`include "dual_issue_macros.svh"

module inst_decode
    import dual_issue_pkg::*;
(
    input  logic [`DI_DATA_W-1:0] inst_i,
    input  logic [`DI_DATA_W-1:0] pc_i,
    input  logic                  valid_i,
    input  logic [`DI_DATA_W-1:0] rdata_a_i,
    input  logic [`DI_DATA_W-1:0] rdata_b_i,
    input  result_slot_t          ex1_i,
    input  result_slot_t          ex2_i,
    input  result_slot_t          wb1_i,
    input  result_slot_t          wb2_i,
    output logic [`DI_REG_AW-1:0] raddr_a_o,
    output logic [`DI_REG_AW-1:0] raddr_b_o,
    output issue_slot_t           slot_o
);
    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [`DI_REG_AW-1:0] rs;
    logic [`DI_REG_AW-1:0] rt;
    logic [`DI_REG_AW-1:0] rd;
    logic [15:0]           imm;
    logic [`DI_REG_AW-1:0] waddr;
    logic [`DI_DATA_W-1:0] imm_ext;
    alu_op_e               alu_op;
    logic                  use_imm;

    // Youngest producer first
    function automatic logic [`DI_DATA_W-1:0] resolve(
        input logic [`DI_REG_AW-1:0] addr,
        input logic [`DI_DATA_W-1:0] rf_val,
        input result_slot_t          e2,
        input result_slot_t          e1,
        input result_slot_t          w2,
        input result_slot_t          w1
    );
        if (e2.we && e2.waddr == addr) begin
            return e2.wdata;
        end else if (e1.we && e1.waddr == addr) begin
            return e1.wdata;
        end else if (w2.we && w2.waddr == addr) begin
            return w2.wdata;
        end else if (w1.we && w1.waddr == addr) begin
            return w1.wdata;
        end
        return rf_val;
    endfunction

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign imm    = inst_i[15:0];
    assign funct  = inst_i[5:0];

    assign raddr_a_o = rs;
    assign raddr_b_o = rt;

    always_comb begin
        alu_op  = ALU_NOP;
        use_imm = 1'b0;
        imm_ext = '0;
        case (opcode)
            `DI_OP_SPECIAL: begin
                case (funct)
                    `DI_FN_ADDU: alu_op = ALU_ADD;
                    `DI_FN_SUBU: alu_op = ALU_SUB;
                    `DI_FN_AND:  alu_op = ALU_AND;
                    `DI_FN_OR:   alu_op = ALU_OR;
                    `DI_FN_XOR:  alu_op = ALU_XOR;
                    `DI_FN_SLT:  alu_op = ALU_SLT;
                    default:     alu_op = ALU_NOP;
                endcase
            end
            `DI_OP_ADDIU: begin
                alu_op  = ALU_ADD;
                use_imm = 1'b1;
                imm_ext = {{16{imm[15]}}, imm};
            end
            `DI_OP_ANDI: begin
                alu_op  = ALU_AND;
                use_imm = 1'b1;
                imm_ext = {16'h0000, imm};
            end
            `DI_OP_ORI: begin
                alu_op  = ALU_OR;
                use_imm = 1'b1;
                imm_ext = {16'h0000, imm};
            end
            `DI_OP_LUI: begin
                alu_op  = ALU_LUI;
                use_imm = 1'b1;
                imm_ext = {16'h0000, imm};
            end
            default: alu_op = ALU_NOP;
        endcase
        // Empty slot acts as a no-op
        if (!valid_i) begin
            alu_op = ALU_NOP;
        end
    end

    // Immediate forms write rt, register forms rd
    assign waddr = use_imm ? rt : rd;

    always_comb begin
        slot_o.valid   = valid_i;
        slot_o.pc      = pc_i;
        slot_o.alu_op  = alu_op;
        slot_o.rs      = rs;
        slot_o.rt      = rt;
        slot_o.use_imm = use_imm;
        slot_o.op_a    = resolve(rs, rdata_a_i, ex2_i, ex1_i, wb2_i, wb1_i);
        slot_o.op_b    = use_imm ? imm_ext
                                 : resolve(rt, rdata_b_i, ex2_i, ex1_i, wb2_i, wb1_i);
        slot_o.waddr   = waddr;
        slot_o.we      = (alu_op != ALU_NOP) && (waddr != '0);
    end

endmodule

// File: hdl/pipe_stage_reg.sv
//////////////////////////////
// Generic pipeline register, one stage.
// Payload type is set per instance, zeroed on reset.
//////////////////////////////
`include "dual_issue_macros.svh"

module pipe_stage_reg
    import dual_issue_pkg::*;
#(
    parameter type payload_t = result_slot_t
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else begin
            q_o <= d_i;
        end
    end

endmodule

// File: hdl/dual_alu.sv
//////////////////////////////
// Execute stage with one ALU per slot.
// Slot 1's result feeds slot 2 directly within a pair.
//////////////////////////////
`include "dual_issue_macros.svh"

module dual_alu
    import dual_issue_pkg::*;
(
    input  issue_slot_t  slot1_i,
    input  issue_slot_t  slot2_i,
    output result_slot_t res1_o,
    output result_slot_t res2_o
);
    logic [`DI_DATA_W-1:0] result1;
    logic [`DI_DATA_W-1:0] result2;
    logic [`DI_DATA_W-1:0] op_a2;
    logic [`DI_DATA_W-1:0] op_b2;
    logic                  slot1_writes;

    function automatic logic [`DI_DATA_W-1:0] alu(
        input alu_op_e               op,
        input logic [`DI_DATA_W-1:0] a,
        input logic [`DI_DATA_W-1:0] b
    );
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT: return {{(`DI_DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_LUI: return b << 16;
            default: return '0;
        endcase
    endfunction

    assign result1 = alu(slot1_i.alu_op, slot1_i.op_a, slot1_i.op_b);

    ////////////////////////////// intra-pair chain
    assign slot1_writes = slot1_i.valid && slot1_i.we;

    assign op_a2 = (slot1_writes && slot1_i.waddr == slot2_i.rs) ? result1 : slot2_i.op_a;
    // rt is only a source for register forms
    assign op_b2 = (slot1_writes && !slot2_i.use_imm && slot1_i.waddr == slot2_i.rt)
                 ? result1 : slot2_i.op_b;

    assign result2 = alu(slot2_i.alu_op, op_a2, op_b2);

    assign res1_o.pc    = slot1_i.pc;
    assign res1_o.we    = slot1_writes;
    assign res1_o.waddr = slot1_i.waddr;
    assign res1_o.wdata = result1;

    assign res2_o.pc    = slot2_i.pc;
    assign res2_o.we    = slot2_i.valid && slot2_i.we;
    assign res2_o.waddr = slot2_i.waddr;
    assign res2_o.wdata = result2;

endmodule

// File: hdl/writeback_stage.sv
//////////////////////////////
// Result stage, registers execute results.
// Drives register-file writes, forwarding and the commit debug ports.
//////////////////////////////
`include "dual_issue_macros.svh"

module writeback_stage
    import dual_issue_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  result_slot_t          res1_i,
    input  result_slot_t          res2_i,
    output result_slot_t          wb1_o,
    output result_slot_t          wb2_o,
    output logic [`DI_DATA_W-1:0] commit_pc1_o,
    output logic                  commit_rf_wen1_o,
    output logic [`DI_REG_AW-1:0] commit_rf_waddr1_o,
    output logic [`DI_DATA_W-1:0] commit_rf_wdata1_o,
    output logic [`DI_DATA_W-1:0] commit_pc2_o,
    output logic                  commit_rf_wen2_o,
    output logic [`DI_REG_AW-1:0] commit_rf_waddr2_o,
    output logic [`DI_DATA_W-1:0] commit_rf_wdata2_o
);
    // Index 0 is slot 1
    typedef result_slot_t [1:0] result_pair_t;

    result_pair_t res_q;

    pipe_stage_reg #(
        .payload_t (result_pair_t)
    ) u_res_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .d_i      ({res2_i, res1_i}),
        .q_o      (res_q)
    );

    assign wb1_o = res_q[0];
    assign wb2_o = res_q[1];

    ////////////////////////////// commit debug
    assign commit_pc1_o       = res_q[0].pc;
    assign commit_rf_wen1_o   = res_q[0].we;
    assign commit_rf_waddr1_o = res_q[0].waddr;
    assign commit_rf_wdata1_o = res_q[0].wdata;

    // Slot 2 always sits one word after slot 1
    assign commit_pc2_o       = res_q[0].pc + `DI_PC_STEP;
    assign commit_rf_wen2_o   = res_q[1].we;
    assign commit_rf_waddr2_o = res_q[1].waddr;
    assign commit_rf_wdata2_o = res_q[1].wdata;

endmodule

// File: hdl/dual_issue_core.sv
//////////////////////////////
// Two-wide in-order integer core, top level.
// Takes one instruction pair per cycle, commits two cycles later.
//////////////////////////////
`include "dual_issue_macros.svh"

module dual_issue_core
    import dual_issue_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [`DI_DATA_W-1:0] inst1_i,
    input  logic [`DI_DATA_W-1:0] inst2_i,
    input  logic [`DI_DATA_W-1:0] pc_i,
    input  logic                  pair_valid_i,
    input  logic                  slot2_valid_i,
    output logic [`DI_DATA_W-1:0] commit_pc1_o,
    output logic                  commit_rf_wen1_o,
    output logic [`DI_REG_AW-1:0] commit_rf_waddr1_o,
    output logic [`DI_DATA_W-1:0] commit_rf_wdata1_o,
    output logic [`DI_DATA_W-1:0] commit_pc2_o,
    output logic                  commit_rf_wen2_o,
    output logic [`DI_REG_AW-1:0] commit_rf_waddr2_o,
    output logic [`DI_DATA_W-1:0] commit_rf_wdata2_o
);
    typedef issue_slot_t [1:0] issue_pair_t;

    logic [`DI_REG_AW-1:0] rf_raddr1, rf_raddr2, rf_raddr3, rf_raddr4;
    logic [`DI_DATA_W-1:0] rf_rdata1, rf_rdata2, rf_rdata3, rf_rdata4;
    logic [`DI_DATA_W-1:0] pc2;
    logic                  slot2_valid;
    issue_slot_t           id_slot1, id_slot2;
    issue_pair_t           ex_pair;
    result_slot_t          ex_res1, ex_res2;
    result_slot_t          wb1, wb2;

    assign pc2         = pc_i + `DI_PC_STEP;
    assign slot2_valid = pair_valid_i & slot2_valid_i;

    reg_file u_reg_file (
        .clk (clk), .arst_n_i (arst_n_i),
        .we1_i (wb1.we), .waddr1_i (wb1.waddr), .wdata1_i (wb1.wdata),
        .we2_i (wb2.we), .waddr2_i (wb2.waddr), .wdata2_i (wb2.wdata),
        .raddr1_i (rf_raddr1), .raddr2_i (rf_raddr2),
        .raddr3_i (rf_raddr3), .raddr4_i (rf_raddr4),
        .rdata1_o (rf_rdata1), .rdata2_o (rf_rdata2),
        .rdata3_o (rf_rdata3), .rdata4_o (rf_rdata4)
    );

    ////////////////////////////// decode
    inst_decode u_decode1 (
        .inst_i (inst1_i), .pc_i (pc_i), .valid_i (pair_valid_i),
        .rdata_a_i (rf_rdata1), .rdata_b_i (rf_rdata2),
        .ex1_i (ex_res1), .ex2_i (ex_res2), .wb1_i (wb1), .wb2_i (wb2),
        .raddr_a_o (rf_raddr1), .raddr_b_o (rf_raddr2), .slot_o (id_slot1)
    );

    inst_decode u_decode2 (
        .inst_i (inst2_i), .pc_i (pc2), .valid_i (slot2_valid),
        .rdata_a_i (rf_rdata3), .rdata_b_i (rf_rdata4),
        .ex1_i (ex_res1), .ex2_i (ex_res2), .wb1_i (wb1), .wb2_i (wb2),
        .raddr_a_o (rf_raddr3), .raddr_b_o (rf_raddr4), .slot_o (id_slot2)
    );

    pipe_stage_reg #(
        .payload_t (issue_pair_t)
    ) u_id_ex_reg (
        .clk (clk), .arst_n_i (arst_n_i),
        .d_i ({id_slot2, id_slot1}), .q_o (ex_pair)
    );

    ////////////////////////////// execute and commit
    dual_alu u_alu (
        .slot1_i (ex_pair[0]), .slot2_i (ex_pair[1]),
        .res1_o (ex_res1), .res2_o (ex_res2)
    );

    writeback_stage u_wb (
        .clk (clk), .arst_n_i (arst_n_i),
        .res1_i (ex_res1), .res2_i (ex_res2),
        .wb1_o (wb1), .wb2_o (wb2),
        .commit_pc1_o (commit_pc1_o), .commit_rf_wen1_o (commit_rf_wen1_o),
        .commit_rf_waddr1_o (commit_rf_waddr1_o), .commit_rf_wdata1_o (commit_rf_wdata1_o),
        .commit_pc2_o (commit_pc2_o), .commit_rf_wen2_o (commit_rf_wen2_o),
        .commit_rf_waddr2_o (commit_rf_waddr2_o), .commit_rf_wdata2_o (commit_rf_wdata2_o)
    );

endmodule

// File: tb/dual_issue_checker.sv
//////////////////////////////
// Commit port assertions for the dual-issue core.
// Bound to the core at the end of this file.
//////////////////////////////
`include "dual_issue_macros.svh"

module dual_issue_checker (
    input logic                  clk,
    input logic                  arst_n_i,
    input logic                  wen1_i,
    input logic [`DI_REG_AW-1:0] waddr1_i,
    input logic [`DI_DATA_W-1:0] wdata1_i,
    input logic                  wen2_i,
    input logic [`DI_REG_AW-1:0] waddr2_i,
    input logic [`DI_DATA_W-1:0] wdata2_i
);

    // Count of assertion failures
    int fail_count = 0;

    // Quiet while reset is held
    a_no_wen_in_reset: assert property (@(posedge clk) !arst_n_i |-> !(wen1_i || wen2_i))
        else begin
            $error("commit write enable high during reset");
            fail_count = fail_count + 1;
        end

    a_no_zero_waddr1: assert property (@(posedge clk) disable iff (!arst_n_i)
        wen1_i |-> waddr1_i != '0)
        else begin
            $error("slot 1 commits a write to register zero");
            fail_count = fail_count + 1;
        end

    a_no_zero_waddr2: assert property (@(posedge clk) disable iff (!arst_n_i)
        wen2_i |-> waddr2_i != '0)
        else begin
            $error("slot 2 commits a write to register zero");
            fail_count = fail_count + 1;
        end

    a_known_wdata1: assert property (@(posedge clk) disable iff (!arst_n_i)
        wen1_i |-> !$isunknown(wdata1_i))
        else begin
            $error("slot 1 write data has unknown bits");
            fail_count = fail_count + 1;
        end

    a_known_wdata2: assert property (@(posedge clk) disable iff (!arst_n_i)
        wen2_i |-> !$isunknown(wdata2_i))
        else begin
            $error("slot 2 write data has unknown bits");
            fail_count = fail_count + 1;
        end

endmodule

bind dual_issue_core dual_issue_checker u_checker (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .wen1_i   (commit_rf_wen1_o),
    .waddr1_i (commit_rf_waddr1_o),
    .wdata1_i (commit_rf_wdata1_o),
    .wen2_i   (commit_rf_wen2_o),
    .waddr2_i (commit_rf_waddr2_o),
    .wdata2_i (commit_rf_wdata2_o)
);

// File: tb/dual_issue_tb.sv
//////////////////////////////
// Testbench for the dual-issue core.
// Directed and random pairs checked against a register model.
//////////////////////////////
`include "dual_issue_macros.svh"

module dual_issue_tb;

    localparam int RESET_CYCLES    = 4;
    localparam int DIRECTED_CYCLES = 20;
    localparam int RAND_PAIRS      = 400;
    localparam int MAX_CYCLES      = RESET_CYCLES + DIRECTED_CYCLES + RAND_PAIRS + 20;

    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } write_t;

    typedef struct {
        string       name;
        int          tag;
        logic [31:0] pc;
        write_t      w1;
        write_t      w2;
    } expect_t;

    logic        clk = 1'b0;
    logic        arst_n_i;
    logic [31:0] inst1_i, inst2_i, pc_i;
    logic        pair_valid_i, slot2_valid_i;
    logic [31:0] commit_pc1_o, commit_pc2_o, commit_rf_wdata1_o, commit_rf_wdata2_o;
    logic        commit_rf_wen1_o, commit_rf_wen2_o;
    logic [4:0]  commit_rf_waddr1_o, commit_rf_waddr2_o;

    logic [31:0] model_rf [32];
    expect_t     exp_q [$];
    string       test_name;
    logic [31:0] next_pc;
    int          cycle = 0;

    dual_issue_core DUT (.*);

    always #2 clk = ~clk;

    // Cycle count and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d commits outstanding", cycle, exp_q.size());
            $display("Result: FAILED");
            $fatal(1, "Run limit reached");
        end
    end

    function automatic logic [31:0] encode_r(input logic [5:0] fn, input logic [4:0] rd,
                                             input logic [4:0] rs, input logic [4:0] rt);
        return {`DI_OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rt,
                                             input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Expected write of one instruction on the current model state
    function automatic write_t expected_write(input logic [31:0] rf [32], input logic [31:0] inst);
        write_t      w;
        logic [31:0] a;
        logic [31:0] b;
        a       = rf[inst[25:21]];
        b       = rf[inst[20:16]];
        w.we    = 1'b1;
        w.waddr = inst[20:16];
        w.wdata = '0;
        case (inst[31:26])
            `DI_OP_ADDIU: w.wdata = a + {{16{inst[15]}}, inst[15:0]};
            `DI_OP_ANDI:  w.wdata = a & {16'h0000, inst[15:0]};
            `DI_OP_ORI:   w.wdata = a | {16'h0000, inst[15:0]};
            `DI_OP_LUI:   w.wdata = {inst[15:0], 16'h0000};
            `DI_OP_SPECIAL: begin
                w.waddr = inst[15:11];
                case (inst[5:0])
                    `DI_FN_ADDU: w.wdata = a + b;
                    `DI_FN_SUBU: w.wdata = a - b;
                    `DI_FN_AND:  w.wdata = a & b;
                    `DI_FN_OR:   w.wdata = a | b;
                    `DI_FN_XOR:  w.wdata = a ^ b;
                    `DI_FN_SLT:  w.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:     w.we = 1'b0;
                endcase
            end
            default: w.we = 1'b0;
        endcase
        if (w.waddr == 5'd0) begin
            w.we = 1'b0;
        end
        return w;
    endfunction

    function automatic logic [31:0] random_inst();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        // Few registers, so dependencies are dense
        rs  = 5'($urandom_range(0, 5));
        rt  = 5'($urandom_range(0, 5));
        rd  = 5'($urandom_range(0, 5));
        imm = 16'($urandom);
        case ($urandom_range(0, 10))
            0:       return encode_r(`DI_FN_ADDU, rd, rs, rt);
            1:       return encode_r(`DI_FN_SUBU, rd, rs, rt);
            2:       return encode_r(`DI_FN_AND, rd, rs, rt);
            3:       return encode_r(`DI_FN_OR, rd, rs, rt);
            4:       return encode_r(`DI_FN_XOR, rd, rs, rt);
            5:       return encode_r(`DI_FN_SLT, rd, rs, rt);
            6:       return encode_i(`DI_OP_ADDIU, rt, rs, imm);
            7:       return encode_i(`DI_OP_ANDI, rt, rs, imm);
            8:       return encode_i(`DI_OP_ORI, rt, rs, imm);
            9:       return encode_i(`DI_OP_LUI, rt, rs, imm);
            default: return $urandom;
        endcase
    endfunction

    task automatic send_pair(input logic [31:0] i1, input logic [31:0] i2, input logic s2v);
        expect_t e;
        @(posedge clk);
        inst1_i       <= i1;
        inst2_i       <= i2;
        pc_i          <= next_pc;
        pair_valid_i  <= 1'b1;
        slot2_valid_i <= s2v;
        // Counter still holds its pre-edge value here
        e.name = test_name;
        e.tag  = cycle + 3;
        e.pc   = next_pc;
        e.w1   = expected_write(model_rf, i1);
        if (e.w1.we) begin
            model_rf[e.w1.waddr] = e.w1.wdata;
        end
        e.w2 = '0;
        if (s2v) begin
            e.w2 = expected_write(model_rf, i2);
            if (e.w2.we) begin
                model_rf[e.w2.waddr] = e.w2.wdata;
            end
        end
        exp_q.push_back(e);
        next_pc = next_pc + 32'd8;
    endtask

    task automatic go_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            pair_valid_i  <= 1'b0;
            slot2_valid_i <= 1'b0;
        end
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expv, input logic [31:0] actv);
        assert (actv === expv) else begin
            $display("error: %s %s expected %08h actual %08h", name, field, expv, actv);
            $display("Result: FAILED");
            $fatal(1, "Mismatch on %s", field);
        end
    endtask

    task automatic check_write(input string name, input string slot, input write_t w,
                               input logic wen, input logic [4:0] waddr, input logic [31:0] wdata);
        check_value(name, {"wen", slot}, 32'(w.we), 32'(wen));
        if (w.we) begin
            check_value(name, {"waddr", slot}, 32'(w.waddr), 32'(waddr));
            check_value(name, {"wdata", slot}, w.wdata, wdata);
        end
    endtask

    ////////////////////////////// compare
    always @(negedge clk) begin : compare
        expect_t e;
        if (exp_q.size() != 0 && exp_q[0].tag == cycle) begin
            e = exp_q.pop_front();
            check_value(e.name, "pc1", e.pc, commit_pc1_o);
            check_value(e.name, "pc2", e.pc + 32'd4, commit_pc2_o);
            check_write(e.name, "1", e.w1, commit_rf_wen1_o, commit_rf_waddr1_o,
                        commit_rf_wdata1_o);
            check_write(e.name, "2", e.w2, commit_rf_wen2_o, commit_rf_waddr2_o,
                        commit_rf_wdata2_o);
        end else begin
            // Bubbles and reset commit nothing
            check_value("idle", "wen1", 32'd0, 32'(commit_rf_wen1_o));
            check_value("idle", "wen2", 32'd0, 32'(commit_rf_wen2_o));
        end
    end

    ////////////////////////////// stimulus
    initial begin
        void'($urandom(32'h534ea69d));
        arst_n_i      = 1'b0;
        inst1_i       = '0;
        inst2_i       = '0;
        pc_i          = '0;
        pair_valid_i  = 1'b0;
        slot2_valid_i = 1'b0;
        next_pc       = 32'h0000_1000;
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n_i <= 1'b1;

        test_name = "alu_ops";
        send_pair(encode_i(`DI_OP_LUI, 1, 0, 16'h1234), encode_i(`DI_OP_ORI, 2, 0, 16'h00ff), 1);
        send_pair(encode_i(`DI_OP_ORI, 1, 1, 16'h5678), encode_i(`DI_OP_ADDIU, 3, 0, 16'hfffb), 1);
        send_pair(encode_r(`DI_FN_ADDU, 4, 1, 2), encode_r(`DI_FN_SUBU, 5, 2, 3), 1);
        send_pair(encode_r(`DI_FN_AND, 6, 1, 2), encode_r(`DI_FN_OR, 7, 1, 3), 1);
        send_pair(encode_r(`DI_FN_XOR, 8, 4, 5), encode_r(`DI_FN_SLT, 9, 3, 2), 1);
        send_pair(encode_r(`DI_FN_SLT, 10, 2, 3), encode_i(`DI_OP_ANDI, 11, 1, 16'hf0f0), 1);

        test_name = "forwarding";
        send_pair(encode_i(`DI_OP_ADDIU, 12, 4, 16'd1), encode_i(`DI_OP_ADDIU, 13, 5, 16'd2), 1);
        send_pair(encode_r(`DI_FN_ADDU, 14, 12, 13), encode_r(`DI_FN_ADDU, 15, 12, 7), 1);
        send_pair(encode_r(`DI_FN_SUBU, 16, 14, 12), encode_r(`DI_FN_XOR, 17, 15, 13), 1);

        test_name = "intra_pair";
        send_pair(encode_i(`DI_OP_ADDIU, 18, 1, 16'd7), encode_r(`DI_FN_ADDU, 19, 18, 18), 1);
        send_pair(encode_i(`DI_OP_ORI, 20, 0, 16'h11), encode_i(`DI_OP_ORI, 20, 0, 16'h22), 1);
        send_pair(encode_r(`DI_FN_ADDU, 21, 20, 0), encode_i(`DI_OP_ADDIU, 22, 20, 16'd0), 1);
        go_idle(3);
        send_pair(encode_r(`DI_FN_ADDU, 23, 20, 19), encode_r(`DI_FN_SLT, 24, 23, 19), 1);

        test_name = "no_write";
        send_pair(encode_i(`DI_OP_ADDIU, 0, 1, 16'd5), encode_r(`DI_FN_ADDU, 0, 2, 3), 1);
        send_pair(32'hffff_ffff, encode_r(6'h00, 1, 2, 3), 1);
        send_pair(encode_i(`DI_OP_ADDIU, 25, 0, 16'd9), encode_i(`DI_OP_ADDIU, 26, 0, 16'h33), 0);
        send_pair(encode_r(`DI_FN_ADDU, 27, 26, 25), encode_r(`DI_FN_ADDU, 28, 1, 0), 1);

        test_name = "random";
        repeat (RAND_PAIRS) begin
            send_pair(random_inst(), random_inst(), $urandom_range(0, 7) != 0);
        end
        go_idle(1);
        wait (exp_q.size() == 0);
        @(negedge clk);

        if (DUT.u_checker.fail_count != 0) begin
            $display("Commit port assertions failed %0d times", DUT.u_checker.fail_count);
            $display("Result: FAILED");
            $fatal(1, "Assertion failures");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// File: flist.f
+incdir+hdl
hdl/dual_issue_pkg.sv
hdl/reg_file.sv
hdl/inst_decode.sv
hdl/pipe_stage_reg.sv
hdl/dual_alu.sv
hdl/writeback_stage.sv
hdl/dual_issue_core.sv
tb/dual_issue_checker.sv
tb/dual_issue_tb.sv

// File: Bender.yml
package:
  name: dual_issue_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dual_issue_pkg.sv
      - hdl/reg_file.sv
      - hdl/inst_decode.sv
      - hdl/pipe_stage_reg.sv
      - hdl/dual_alu.sv
      - hdl/writeback_stage.sv
      - hdl/dual_issue_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/dual_issue_checker.sv
      - tb/dual_issue_tb.sv
